// File: filelist.f
+incdir+include
verilog/fetch.sv
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/regFile.sv
verilog/decode.sv
verilog/execution.sv
verilog/memory.sv
verilog/proc.sv
testbench/tb_proc.sv

// File: include/proc_consts.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core sizing. Depths must be powers of two, and addresses
// are byte addresses, so bit 0 is dropped at both memories.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Data path and instruction word width
`define WORD_W 16

`define REG_COUNT 8

// Memory depths in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`define RESET_PC 16'h0000

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is nonzero when the simulation fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_proc -f filelist.f \
   --Mdir obj_dir -o tb_proc_sim

./obj_dir/tb_proc_sim

// File: testbench/tb_proc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boots each table program through the boot port, runs it to
// halt and compares the commit trace. Stops at the first error.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module tb_proc import isaPkg::*, ctrlPkg::*; ();

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 5;
   localparam int IDLE_CYCLES  = 10;
   localparam int NUM_PROGS    = 6;
   localparam int MAX_WORDS    = 16;
   localparam int MAX_COMMITS  = 12;
   localparam int IMEM_AW      = $clog2(`IMEM_DEPTH);

   logic               clk;
   logic               rstN;
   logic               progWrEn;
   logic [IMEM_AW-1:0] progAddr;
   logic [`WORD_W-1:0] progData;
   commitT             commit;
   logic               halt;
   logic               err;

   // Program table with one row per program and commits packed as {wrAddr, wrData}
   string              progName  [NUM_PROGS];
   logic [`WORD_W-1:0] progWords [NUM_PROGS][MAX_WORDS];
   int                 progLen   [NUM_PROGS];
   logic [`WORD_W+2:0] expCommit [NUM_PROGS][MAX_COMMITS];
   int                 expCount  [NUM_PROGS];
   logic               expErr    [NUM_PROGS];
   int                 cur;
   logic [31:0]        lfsrState;
   logic               tableReady;

   proc i_proc (
      .clk      (clk),
      .rstN     (rstN),
      .progWrEn (progWrEn),
      .progAddr (progAddr),
      .progData (progData),
      .commit   (commit),
      .halt     (halt),
      .err      (err)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [15:0] encodeReg(opcodeT op, int rs, int rt, int rd, functT fn);
      return {op, 3'(rs), 3'(rt), 3'(rd), fn};
   endfunction

   function automatic logic [15:0] encodeImm(opcodeT op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic logic [15:0] encodeByte(opcodeT op, int rs, int imm);
      return {op, 3'(rs), 8'(imm)};
   endfunction

   function automatic logic [15:0] encodeJump(opcodeT op, int disp);
      return {op, 11'(disp)};
   endfunction

   function automatic logic [15:0] signExtend(int raw, int width);
      logic [15:0] field;
      field = 16'(raw) & ~(16'hFFFF << width);
      if (field[width-1]) begin
         field = field | (16'hFFFF << width);
      end
      return field;
   endfunction

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1
   function automatic logic nextLfsrBit();
      logic outBit;
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) begin
         lfsrState = lfsrState ^ 32'h8020_0003;
      end
      return outBit;
   endfunction

   function automatic int randomBits(int count);
      int value;
      value = 0;
      for (int i = 0; i < count; i++) begin
         value = (value << 1) | int'(nextLfsrBit());
      end
      return value;
   endfunction

   task automatic compareValues(string name, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic startProgram(string name, logic endsInErr);
      cur++;
      progName[cur] = name;
      progLen[cur]  = 0;
      expCount[cur] = 0;
      expErr[cur]   = endsInErr;
   endtask

   task automatic addWord(logic [15:0] word);
      progWords[cur][progLen[cur]] = word;
      progLen[cur]++;
   endtask

   // Word that must commit a register write
   task automatic addWordWrite(logic [15:0] word, int addr, logic [15:0] data);
      addWord(word);
      expCommit[cur][expCount[cur]] = {regIdxT'(addr), data};
      expCount[cur]++;
   endtask

   task automatic buildTable();
      int          a;
      int          b;
      int          c;
      int          d;
      logic [15:0] r1v;
      logic [15:0] r2v;
      logic [15:0] r3v;
      logic [15:0] r4v;
      startProgram("arith", 1'b0);
      addWordWrite(encodeByte(opLbi, 1, 'h35), 1, 16'h0035);
      addWordWrite(encodeByte(opLbi, 2, -7), 2, 16'hFFF9);
      addWordWrite(encodeReg(opAlu, 1, 2, 3, fnAdd), 3, 16'h002E);
      addWordWrite(encodeReg(opAlu, 1, 2, 4, fnSub), 4, 16'h003C);
      addWordWrite(encodeReg(opAlu, 1, 2, 5, fnXor), 5, 16'hFFCC);
      addWordWrite(encodeReg(opAlu, 1, 2, 6, fnAnd), 6, 16'h0031);
      addWordWrite(encodeImm(opAddi, 1, 7, -16), 7, 16'h0025);
      addWord(encodeJump(opHalt, 0));

      startProgram("setcond", 1'b0);
      addWordWrite(encodeByte(opLbi, 1, -3), 1, 16'hFFFD);
      addWordWrite(encodeByte(opLbi, 2, 4), 2, 16'h0004);
      addWordWrite(encodeReg(opSlt, 1, 2, 3, fnAdd), 3, 16'h0001);
      addWordWrite(encodeReg(opSlt, 2, 1, 4, fnAdd), 4, 16'h0000);
      addWordWrite(encodeReg(opSeq, 1, 2, 5, fnAdd), 5, 16'h0000);
      addWordWrite(encodeReg(opSeq, 1, 1, 6, fnAdd), 6, 16'h0001);
      addWordWrite(encodeByte(opLbi, 7, -8), 7, 16'hFFF8);
      addWordWrite(encodeReg(opSlt, 7, 1, 3, fnAdd), 3, 16'h0001);
      addWord(encodeJump(opHalt, 0));

      // Stores hit 0x20 and 0x24 but never 0x22
      startProgram("memory", 1'b0);
      addWordWrite(encodeByte(opLbi, 1, 'h20), 1, 16'h0020);
      addWordWrite(encodeByte(opLbi, 2, 'h5A), 2, 16'h005A);
      addWord(encodeImm(opSt, 1, 2, 0));
      addWordWrite(encodeByte(opLbi, 3, -100), 3, 16'hFF9C);
      addWord(encodeImm(opSt, 1, 3, 4));
      addWordWrite(encodeImm(opLd, 1, 4, 0), 4, 16'h005A);
      addWordWrite(encodeImm(opLd, 1, 5, 4), 5, 16'hFF9C);
      addWordWrite(encodeImm(opLd, 1, 6, 2), 6, 16'h0000);
      addWordWrite(encodeImm(opAddi, 4, 7, 1), 7, 16'h005B);
      addWord(encodeJump(opHalt, 0));

      // Words 3 and 7 never run and JAL jumps over 11 and 12 on the first pass
      startProgram("branch", 1'b0);
      addWordWrite(encodeByte(opLbi, 1, 0), 1, 16'h0000);
      addWordWrite(encodeByte(opLbi, 2, 5), 2, 16'h0005);
      addWord(encodeByte(opBeqz, 1, 2));
      addWord(encodeByte(opLbi, 3, 'h11));
      addWord(encodeByte(opBnez, 1, 2));
      addWordWrite(encodeByte(opLbi, 4, 'h22), 4, 16'h0022);
      addWord(encodeByte(opBnez, 2, 2));
      addWord(encodeByte(opLbi, 3, 'h33));
      addWord(encodeByte(opBeqz, 2, 2));
      addWordWrite(encodeByte(opLbi, 5, 'h44), 5, 16'h0044);
      addWordWrite(encodeJump(opJal, 4), 7, 16'h0016);
      addWordWrite(encodeByte(opLbi, 6, 'h55), 6, 16'h0055);
      addWord(encodeJump(opHalt, 0));
      addWord(encodeJump(opJ, -6));

      // Opcode 00010 is unassigned
      startProgram("illegal", 1'b1);
      addWordWrite(encodeByte(opLbi, 1, 1), 1, 16'h0001);
      addWord(16'h1000);
      addWord(encodeByte(opLbi, 2, 2));

      a   = randomBits(8);
      b   = randomBits(5);
      c   = randomBits(5);
      d   = randomBits(8);
      r1v = signExtend(a, 8);
      r2v = r1v + signExtend(b, 5);
      r3v = r2v + signExtend(c, 5);
      r4v = signExtend(d, 8);
      startProgram("lfsr", 1'b0);
      addWordWrite(encodeByte(opLbi, 1, a), 1, r1v);
      addWordWrite(encodeImm(opAddi, 1, 2, b), 2, r2v);
      addWordWrite(encodeImm(opAddi, 2, 3, c), 3, r3v);
      addWordWrite(encodeByte(opLbi, 4, d), 4, r4v);
      addWordWrite(encodeReg(opAlu, 1, 4, 5, fnAdd), 5, r1v + r4v);
      addWord(encodeJump(opHalt, 0));
   endtask

   // Program words go in first, then the plain reset cycles
   task automatic bootProgram(int p);
      for (int i = 0; i < progLen[p] + RESET_CYCLES; i++) begin
         @(posedge clk);
         rstN <= 1'b0;
         if (i < progLen[p]) begin
            progWrEn <= 1'b1;
            progAddr <= IMEM_AW'(i);
            progData <= progWords[p][i];
         end else begin
            progWrEn <= 1'b0;
         end
      end
      @(negedge clk);
      compareValues({progName[p], " halt after reset"}, 32'd0, 32'(halt));
      compareValues({progName[p], " err after reset"}, 32'd0, 32'(err));
      @(posedge clk);
      rstN <= 1'b1;
   endtask

   task automatic runProgram(int p);
      int n;
      n = 0;
      @(negedge clk);
      while (!halt) begin
         if (commit.wrEn) begin
            if (n < expCount[p]) begin
               compareValues($sformatf("%s commit %0d", progName[p], n),
                  32'(expCommit[p][n]), 32'({commit.wrAddr, commit.wrData}));
            end
            n++;
         end
         @(negedge clk);
      end
      compareValues({progName[p], " commit count"}, expCount[p], n);
      compareValues({progName[p], " err"}, 32'(expErr[p]), 32'(err));
      // Trapped core stays quiet
      for (int i = 0; i < IDLE_CYCLES; i++) begin
         @(negedge clk);
         compareValues({progName[p], " commit after halt"}, 32'd0, 32'(commit.wrEn));
         compareValues({progName[p], " halt held"}, 32'd1, 32'(halt));
      end
   endtask

   // Watchdog allows 20 cycles per word plus the reset time of every program
   initial begin
      int limit;
      wait (tableReady);
      limit = 0;
      for (int p = 0; p < NUM_PROGS; p++) begin
         limit += RESET_CYCLES + progLen[p] + 20 * progLen[p];
      end
      #(limit * CLK_PERIOD);
      $display("Run did not finish within %0d cycles", limit);
      $display("tests failed");
      $fatal(1, "Watchdog timeout");
   end

   initial begin
      clk        = 1'b0;
      rstN       = 1'b0;
      progWrEn   = 1'b0;
      progAddr   = '0;
      progData   = '0;
      tableReady = 1'b0;
      cur        = -1;
      lfsrState  = 32'd83301;
      buildTable();
      tableReady = 1'b1;
      for (int p = 0; p < NUM_PROGS; p++) begin
         bootProgram(p);
         runProgram(p);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// File: verilog/ctrlPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded control and commit trace types shared by the stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "proc_consts.svh"

package ctrlPkg;
   import isaPkg::*;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluAnd,
      aluPassB
   } aluOpT;

   // Register writeback source
   typedef enum logic [2:0] {
      wbAlu,
      wbMem,
      wbImm,
      wbPcPlus2,
      wbSetCond
   } wbSrcT;

   typedef struct packed {
      aluOpT  aluOp;
      logic   useImm;        // Immediate as second ALU operand
      wbSrcT  wbSrc;
      logic   regWrEn;
      regIdxT dest;
      logic   memEn;
      logic   memWr;
      logic   branch;
      logic   branchOnZero;  // Taken when rs is zero
      logic   jump;
      logic   halt;
      logic   illegal;
   } ctrlT;

   // One retired register write
   typedef struct packed {
      logic               wrEn;
      regIdxT             wrAddr;
      logic [`WORD_W-1:0] wrData;
   } commitT;

endpackage

// File: verilog/decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decode, register file and trap flags. halt and
// err are sticky and only a reset clears them.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module decode import isaPkg::*, ctrlPkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  logic [`WORD_W-1:0] instr,
   input  logic               wbEn,
   input  logic [`WORD_W-1:0] wbData,
   output ctrlT               ctrl,
   output logic [`WORD_W-1:0] rsData,
   output logic [`WORD_W-1:0] rtData,
   output logic [`WORD_W-1:0] imm,
   output logic               halt,
   output logic               err
);

   opcodeT             op;
   functT              fn;
   regIdxT             rs;
   regIdxT             rt;
   regIdxT             rdReg;
   regIdxT             rdImm;
   ctrlT               dec;
   logic [`WORD_W-1:0] immFive;
   logic [`WORD_W-1:0] immEight;
   logic [`WORD_W-1:0] immEleven;
   logic               haltQ;
   logic               errQ;
   logic               live;

   assign op    = opcodeT'(instr[15:11]);
   assign fn    = functT'(instr[1:0]);
   assign rs    = instr[10:8];
   assign rt    = instr[7:5];
   assign rdReg = instr[4:2];
   assign rdImm = instr[7:5];

   assign immFive   = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
   assign immEight  = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
   assign immEleven = {{(`WORD_W-11){instr[10]}}, instr[10:0]};

   always_comb begin
      dec       = '0;
      dec.aluOp = aluPassB;
      dec.wbSrc = wbAlu;
      imm       = immFive;
      case (op)
         opNop: ;
         opHalt: dec.halt = 1'b1;
         opAddi: begin
            dec.aluOp   = aluAdd;
            dec.useImm  = 1'b1;
            dec.regWrEn = 1'b1;
            dec.dest    = rdImm;
         end
         opLd: begin
            dec.aluOp   = aluAdd;
            dec.useImm  = 1'b1;
            dec.wbSrc   = wbMem;
            dec.regWrEn = 1'b1;
            dec.dest    = rdImm;
            dec.memEn   = 1'b1;
         end
         // Store data is the rd field, read on port B
         opSt: begin
            dec.aluOp  = aluAdd;
            dec.useImm = 1'b1;
            dec.memEn  = 1'b1;
            dec.memWr  = 1'b1;
         end
         opLbi: begin
            imm         = immEight;
            dec.wbSrc   = wbImm;
            dec.regWrEn = 1'b1;
            dec.dest    = rs;
         end
         opBeqz, opBnez: begin
            imm              = immEight;
            dec.branch       = 1'b1;
            dec.branchOnZero = (op == opBeqz);
         end
         opJ: begin
            imm      = immEleven;
            dec.jump = 1'b1;
         end
         // Link register is the last one
         opJal: begin
            imm         = immEleven;
            dec.jump    = 1'b1;
            dec.wbSrc   = wbPcPlus2;
            dec.regWrEn = 1'b1;
            dec.dest    = regIdxT'(`REG_COUNT - 1);
         end
         opAlu: begin
            case (fn)
               fnAdd: dec.aluOp = aluAdd;
               fnSub: dec.aluOp = aluSub;
               fnXor: dec.aluOp = aluXor;
               fnAnd: dec.aluOp = aluAnd;
               default: dec.aluOp = aluPassB;
            endcase
            dec.regWrEn = 1'b1;
            dec.dest    = rdReg;
         end
         // Xor result of zero means equal, sub picks the signed compare
         opSeq, opSlt: begin
            dec.aluOp   = (op == opSeq) ? aluXor : aluSub;
            dec.wbSrc   = wbSetCond;
            dec.regWrEn = 1'b1;
            dec.dest    = rdReg;
         end
         default: dec.illegal = 1'b1;
      endcase
   end

   // No state changes while booting or after a trap
   assign live = rstN & ~haltQ;

   always_comb begin
      ctrl         = dec;
      ctrl.regWrEn = dec.regWrEn & live;
      ctrl.memWr   = dec.memWr & live;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         haltQ <= 1'b0;
         errQ  <= 1'b0;
      end else if (!haltQ) begin
         haltQ <= dec.halt | dec.illegal;
         errQ  <= dec.illegal;
      end
   end

   assign halt = haltQ;
   assign err  = errQ;

   regFile i_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rs),
      .rdAddrB (rt),
      .wrEn    (wbEn),
      .wrAddr  (ctrl.dest),
      .wrData  (wbData),
      .rdDataA (rsData),
      .rdDataB (rtData)
   );

endmodule

// File: verilog/execution.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU, set compare and next PC. Purely combinational.
// Branch and jump targets are relative to PC+2.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module execution import ctrlPkg::*; (
   input  ctrlT               ctrl,
   input  logic [`WORD_W-1:0] pc,
   input  logic [`WORD_W-1:0] pcPlusTwo,
   input  logic [`WORD_W-1:0] rsData,
   input  logic [`WORD_W-1:0] rtData,
   input  logic [`WORD_W-1:0] imm,
   output logic [`WORD_W-1:0] aluOut,
   output logic               setCond,
   output logic [`WORD_W-1:0] nextPc
);

   logic [`WORD_W-1:0] opB;
   logic [`WORD_W-1:0] target;
   logic               lessThan;
   logic               rsZero;
   logic               taken;

   assign opB = ctrl.useImm ? imm : rtData;

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:   aluOut = rsData + opB;
         aluSub:   aluOut = rsData - opB;
         aluXor:   aluOut = rsData ^ opB;
         aluAnd:   aluOut = rsData & opB;
         aluPassB: aluOut = opB;
         default:  aluOut = opB;
      endcase
   end

   assign lessThan = $signed(rsData) < $signed(opB);

   // SLT runs the ALU as sub, SEQ as xor
   assign setCond = (ctrl.aluOp == aluSub) ? lessThan : (aluOut == '0);

   // Branch resolution
   assign rsZero = (rsData == '0);
   assign taken  = ctrl.branch & (rsZero == ctrl.branchOnZero);
   assign target = pcPlusTwo + imm;

   always_comb begin
      if (ctrl.halt || ctrl.illegal) begin
         // Stay on the trapping word
         nextPc = pc;
      end else if (ctrl.jump || taken) begin
         nextPc = target;
      end else begin
         nextPc = pcPlusTwo;
      end
   end

endmodule

// File: verilog/fetch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC and instruction memory. Boot writes land only while
// rstN is low; the memory itself has no reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module fetch (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           progWrEn,
   input  logic [$clog2(`IMEM_DEPTH)-1:0] progAddr,
   input  logic [`WORD_W-1:0]             progData,
   input  logic [`WORD_W-1:0]             nextPc,
   input  logic                           stall,
   output logic [`WORD_W-1:0]             instr,
   output logic [`WORD_W-1:0]             pc,
   output logic [`WORD_W-1:0]             pcPlusTwo
);

   localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

   logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
   logic [IMEM_AW-1:0] fetchAddr;

   // Boot loader path
   always_ff @(posedge clk) begin
      if (!rstN && progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   // PC holds once the core has trapped
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= `RESET_PC;
      end else if (!stall) begin
         pc <= nextPc;
      end
   end

   // Word index from byte address
   assign fetchAddr = pc[IMEM_AW:1];
   assign instr     = imem[fetchAddr];
   assign pcPlusTwo = pc + `WORD_W'(2);

endmodule

// File: verilog/isaPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set encodings. Opcode values not listed here
// are illegal and trap the core.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "proc_consts.svh"

package isaPkg;

   // Instruction bits 15:11
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opJal  = 5'b00110,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011,
      opSeq  = 5'b11100,
      opSlt  = 5'b11101
   } opcodeT;

   // Bits 1:0 of an opAlu instruction
   typedef enum logic [1:0] {
      fnAdd = 2'b00,
      fnSub = 2'b01,
      fnXor = 2'b10,
      fnAnd = 2'b11
   } functT;

   typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

endpackage

// File: verilog/memory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory and writeback select. Reads are async, so a
// load result reaches the next instruction without a stall.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module memory import ctrlPkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  ctrlT               ctrl,
   input  logic [`WORD_W-1:0] aluOut,
   input  logic [`WORD_W-1:0] storeData,
   input  logic [`WORD_W-1:0] imm,
   input  logic [`WORD_W-1:0] pcPlusTwo,
   input  logic               setCond,
   output logic [`WORD_W-1:0] wbData,
   output commitT             commit
);

   localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

   logic [`WORD_W-1:0] dmem [`DMEM_DEPTH];
   logic [DMEM_AW-1:0] addr;
   logic [`WORD_W-1:0] rdData;

   assign addr   = aluOut[DMEM_AW:1];
   assign rdData = ctrl.memEn ? dmem[addr] : '0;

   // Whole array clears in reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (ctrl.memEn && ctrl.memWr) begin
         dmem[addr] <= storeData;
      end
   end

   always_comb begin
      case (ctrl.wbSrc)
         wbAlu:     wbData = aluOut;
         wbMem:     wbData = rdData;
         wbImm:     wbData = imm;
         wbPcPlus2: wbData = pcPlusTwo;
         wbSetCond: wbData = {{(`WORD_W-1){1'b0}}, setCond};
         default:   wbData = aluOut;
      endcase
   end

   always_comb begin
      commit.wrEn   = ctrl.regWrEn;
      commit.wrAddr = ctrl.dest;
      commit.wrData = wbData;
   end

endmodule

// File: verilog/proc.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle core top. Boot the program with rstN low,
// one word per clock; commit shows each register write.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module proc import ctrlPkg::*; (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           progWrEn,
   input  logic [$clog2(`IMEM_DEPTH)-1:0] progAddr,
   input  logic [`WORD_W-1:0]             progData,
   output commitT                         commit,
   output logic                           halt,
   output logic                           err
);

   logic [`WORD_W-1:0] instr;
   logic [`WORD_W-1:0] pc;
   logic [`WORD_W-1:0] pcPlusTwo;
   logic [`WORD_W-1:0] nextPc;
   ctrlT               ctrl;
   logic [`WORD_W-1:0] rsData;
   logic [`WORD_W-1:0] rtData;
   logic [`WORD_W-1:0] imm;
   logic [`WORD_W-1:0] aluOut;
   logic               setCond;
   logic [`WORD_W-1:0] wbData;

   // Sticky halt freezes the PC
   fetch i_fetch (
      .clk       (clk),
      .rstN      (rstN),
      .progWrEn  (progWrEn),
      .progAddr  (progAddr),
      .progData  (progData),
      .nextPc    (nextPc),
      .stall     (halt),
      .instr     (instr),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo)
   );

   decode i_decode (
      .clk    (clk),
      .rstN   (rstN),
      .instr  (instr),
      .wbEn   (commit.wrEn),
      .wbData (wbData),
      .ctrl   (ctrl),
      .rsData (rsData),
      .rtData (rtData),
      .imm    (imm),
      .halt   (halt),
      .err    (err)
   );

   execution i_execution (
      .ctrl      (ctrl),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo),
      .rsData    (rsData),
      .rtData    (rtData),
      .imm       (imm),
      .aluOut    (aluOut),
      .setCond   (setCond),
      .nextPc    (nextPc)
   );

   memory i_memory (
      .clk       (clk),
      .rstN      (rstN),
      .ctrl      (ctrl),
      .aluOut    (aluOut),
      .storeData (rtData),
      .imm       (imm),
      .pcPlusTwo (pcPlusTwo),
      .setCond   (setCond),
      .wbData    (wbData),
      .commit    (commit)
   );

endmodule

// File: verilog/regFile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, two async reads and one write. A write is
// not bypassed to the reads in the same cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "proc_consts.svh"

module regFile import isaPkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  regIdxT             rdAddrA,
   input  regIdxT             rdAddrB,
   input  logic               wrEn,
   input  regIdxT             wrAddr,
   input  logic [`WORD_W-1:0] wrData,
   output logic [`WORD_W-1:0] rdDataA,
   output logic [`WORD_W-1:0] rdDataB
);

   logic [`WORD_W-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule
